/* design/branch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_unit import rv_decode_pkg::*; (
  input  word_t        fetch_pc,
  input  word_t        reg_rs1,
  input  word_t        reg_rs2,
  input  word_t        imm,
  input  pc_src_t      pc_src,
  input  branch_cond_t branch_cond,
  output word_t        next_pc
);

  logic  taken;
  word_t seq_pc;
  word_t rel_pc;
  word_t jalr_sum;

  assign seq_pc   = fetch_pc + PC_STEP;
  assign rel_pc   = fetch_pc + imm;
  assign jalr_sum = reg_rs1 + imm;

  always_comb begin
    case (branch_cond)
      BR_EQ:   taken = reg_rs1 == reg_rs2;
      BR_NE:   taken = reg_rs1 != reg_rs2;
      BR_LT:   taken = $signed(reg_rs1) < $signed(reg_rs2);
      BR_GE:   taken = $signed(reg_rs1) >= $signed(reg_rs2);
      BR_LTU:  taken = reg_rs1 < reg_rs2;
      BR_GEU:  taken = reg_rs1 >= reg_rs2;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (pc_src)
      PC_JAL:    next_pc = rel_pc;
      // target lsb is dropped
      PC_JALR:   next_pc = {jalr_sum[31:1], 1'b0};
      PC_BRANCH: next_pc = taken ? rel_pc : seq_pc;
      default:   next_pc = seq_pc;
    endcase
  end

endmodule

`default_nettype wire

/* design/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module imm_gen import rv_decode_pkg::*; (
  input  word_t    instr,
  input  imm_fmt_t imm_fmt,
  output word_t    imm
);

  word_t i_imm;
  word_t s_imm;
  word_t b_imm;
  word_t u_imm;
  word_t j_imm;

  // sign always from bit 31
  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign u_imm = {instr[31:12], 12'b0};
  assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (imm_fmt)
      IMM_I:   imm = i_imm;
      IMM_S:   imm = s_imm;
      IMM_B:   imm = b_imm;
      IMM_U:   imm = u_imm;
      IMM_J:   imm = j_imm;
      default: imm = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/instr_classifier.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_classifier import rv_decode_pkg::*; (
  input  word_t        instr,
  output exec_op_t     exec_op,
  output pc_src_t      pc_src,
  output branch_cond_t branch_cond,
  output opa_sel_t     opa_sel,
  output opb_sel_t     opb_sel,
  output imm_fmt_t     imm_fmt,
  output reg_idx_t     rd,
  output reg_idx_t     rs1,
  output reg_idx_t     rs2,
  output logic         valid_instr
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       quad_ok;
  logic       known;
  logic       writes_rd;
  exec_op_t   alu_op;
  exec_op_t   mul_op;

  assign opcode  = instr[6:2];
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  // only 32-bit encodings
  assign quad_ok = instr[1:0] == 2'b11;

  // register file reads straight from the fields
  assign rs1         = instr[19:15];
  assign rs2         = instr[24:20];
  assign branch_cond = funct3;

  // base alu op, shared by register and immediate forms
  always_comb begin
    case (funct3)
      3'b000:  alu_op = EXEC_ADD;
      3'b001:  alu_op = EXEC_SLL;
      3'b010:  alu_op = EXEC_SLT;
      3'b011:  alu_op = EXEC_SLTU;
      3'b100:  alu_op = EXEC_XOR;
      3'b101:  alu_op = (funct7 == F7_ALT) ? EXEC_SRA : EXEC_SRL;
      3'b110:  alu_op = EXEC_OR;
      default: alu_op = EXEC_AND;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  mul_op = EXEC_MUL;
      3'b001:  mul_op = EXEC_MULH;
      3'b010:  mul_op = EXEC_MULHSU;
      3'b011:  mul_op = EXEC_MULHU;
      3'b100:  mul_op = EXEC_DIV;
      3'b101:  mul_op = EXEC_DIVU;
      3'b110:  mul_op = EXEC_REM;
      default: mul_op = EXEC_REMU;
    endcase
  end

  always_comb begin
    exec_op   = EXEC_NONE;
    pc_src    = PC_SEQ;
    opa_sel   = OPA_REG;
    opb_sel   = OPB_REG;
    imm_fmt   = IMM_NONE;
    known     = 1'b0;
    writes_rd = 1'b1;
    if (quad_ok) begin
      case (opcode)
        OPC_LUI: begin
          exec_op = EXEC_LUI;
          imm_fmt = IMM_U;
          opa_sel = OPA_IMM;
          opb_sel = OPB_ZERO;
          known   = 1'b1;
        end
        OPC_AUIPC: begin
          exec_op = EXEC_ADD;
          imm_fmt = IMM_U;
          opa_sel = OPA_PC;
          opb_sel = OPB_IMM;
          known   = 1'b1;
        end
        OPC_JAL, OPC_JALR: begin
          // link value is pc + 4, computed by execute
          exec_op = EXEC_ADD;
          pc_src  = (opcode == OPC_JAL) ? PC_JAL : PC_JALR;
          imm_fmt = (opcode == OPC_JAL) ? IMM_J : IMM_I;
          opa_sel = OPA_PC;
          opb_sel = OPB_FOUR;
          known   = (opcode == OPC_JAL) || (funct3 == 3'b000);
        end
        OPC_BRANCH: begin
          pc_src    = PC_BRANCH;
          imm_fmt   = IMM_B;
          opa_sel   = OPA_ZERO;
          opb_sel   = OPB_ZERO;
          writes_rd = 1'b0;
          // funct3 010 and 011 are reserved
          known     = funct3[2:1] != 2'b01;
        end
        OPC_LOAD: begin
          imm_fmt = IMM_I;
          opb_sel = OPB_IMM;
          case (funct3)
            3'b000:  exec_op = EXEC_LB;
            3'b001:  exec_op = EXEC_LH;
            3'b010:  exec_op = EXEC_LW;
            3'b100:  exec_op = EXEC_LBU;
            3'b101:  exec_op = EXEC_LHU;
            default: exec_op = EXEC_NONE;
          endcase
          known = exec_op != EXEC_NONE;
        end
        OPC_STORE: begin
          imm_fmt   = IMM_S;
          writes_rd = 1'b0;
          case (funct3)
            3'b000:  exec_op = EXEC_SB;
            3'b001:  exec_op = EXEC_SH;
            3'b010:  exec_op = EXEC_SW;
            default: exec_op = EXEC_NONE;
          endcase
          known = exec_op != EXEC_NONE;
        end
        OPC_OP_IMM: begin
          imm_fmt = IMM_I;
          opb_sel = OPB_IMM;
          exec_op = alu_op;
          if (funct3 == 3'b001) begin
            opb_sel = OPB_SHAMT;
            exec_op = (funct7 == F7_BASE) ? alu_op : EXEC_NONE;
          end else if (funct3 == 3'b101) begin
            opb_sel = OPB_SHAMT;
            exec_op = (funct7 == F7_BASE || funct7 == F7_ALT) ? alu_op : EXEC_NONE;
          end
          known = exec_op != EXEC_NONE;
        end
        OPC_OP: begin
          // imm only feeds mem_addr here
          imm_fmt = IMM_I;
          case (funct7)
            F7_BASE:   exec_op = alu_op;
            F7_ALT:    exec_op = (funct3 == 3'b000) ? EXEC_SUB :
                                 (funct3 == 3'b101) ? alu_op : EXEC_NONE;
            F7_MULDIV: exec_op = mul_op;
            default:   exec_op = EXEC_NONE;
          endcase
          known = exec_op != EXEC_NONE;
        end
        OPC_SYSTEM: begin
          imm_fmt = IMM_I;
          exec_op = (|instr[31:20]) ? EXEC_EBREAK : EXEC_ECALL;
          // csr forms fail here on funct3
          known   = funct3 == 3'b000 && instr[19:15] == 5'd0 && instr[11:7] == 5'd0;
        end
        default: known = 1'b0;
      endcase
    end
    if (!known) begin
      exec_op   = EXEC_NONE;
      pc_src    = PC_SEQ;
      opa_sel   = OPA_REG;
      opb_sel   = OPB_REG;
      imm_fmt   = IMM_NONE;
      writes_rd = 1'b0;
    end
  end

  assign rd          = writes_rd ? instr[11:7] : '0;
  assign valid_instr = known;

endmodule

`default_nettype wire

/* design/operand_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_stage import rv_decode_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  word_t    fetch_pc,
  input  word_t    reg_rs1,
  input  word_t    reg_rs2,
  input  word_t    imm,
  input  word_t    next_pc,
  input  opa_sel_t opa_sel,
  input  opb_sel_t opb_sel,
  input  exec_op_t exec_op,
  input  reg_idx_t rd,
  input  logic     valid_instr,
  output word_t    pc,
  output word_t    mem_addr,
  output word_t    op_a,
  output word_t    op_b,
  output reg_idx_t out_rd,
  output exec_op_t out_exec_op,
  output logic     out_valid
);

  word_t op_a_d;
  word_t op_b_d;
  word_t addr_d;

  always_comb begin
    case (opa_sel)
      OPA_REG: op_a_d = reg_rs1;
      OPA_PC:  op_a_d = fetch_pc;
      OPA_IMM: op_a_d = imm;
      default: op_a_d = '0;
    endcase
  end

  always_comb begin
    case (opb_sel)
      OPB_REG:   op_b_d = reg_rs2;
      OPB_IMM:   op_b_d = imm;
      // shamt sits in the low five immediate bits
      OPB_SHAMT: op_b_d = {27'b0, imm[4:0]};
      OPB_FOUR:  op_b_d = PC_STEP;
      default:   op_b_d = '0;
    endcase
  end

  // address is formed for every instruction, execute ignores it
  // unless it is a load or store
  assign addr_d = reg_rs1 + imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      mem_addr    <= '0;
      op_a        <= '0;
      op_b        <= '0;
      out_rd      <= '0;
      out_exec_op <= EXEC_NONE;
      out_valid   <= 1'b0;
    end else begin
      pc          <= next_pc;
      mem_addr    <= addr_d;
      op_a        <= op_a_d;
      op_b        <= op_b_d;
      out_rd      <= rd;
      out_exec_op <= exec_op;
      out_valid   <= valid_instr;
    end
  end

endmodule

`default_nettype wire

/* design/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  exec_op_t;
  typedef logic [2:0]  imm_fmt_t;
  typedef logic [1:0]  pc_src_t;
  typedef logic [1:0]  opa_sel_t;
  typedef logic [2:0]  opb_sel_t;
  typedef logic [2:0]  branch_cond_t;

  localparam word_t PC_STEP = 32'd4;

  // execute operations, zero means nothing for execute
  localparam exec_op_t EXEC_NONE   = 5'd0;
  localparam exec_op_t EXEC_ADD    = 5'd1;
  localparam exec_op_t EXEC_SUB    = 5'd2;
  localparam exec_op_t EXEC_XOR    = 5'd3;
  localparam exec_op_t EXEC_OR     = 5'd4;
  localparam exec_op_t EXEC_AND    = 5'd5;
  localparam exec_op_t EXEC_SLL    = 5'd6;
  localparam exec_op_t EXEC_SLT    = 5'd7;
  localparam exec_op_t EXEC_SLTU   = 5'd8;
  localparam exec_op_t EXEC_SRL    = 5'd9;
  localparam exec_op_t EXEC_SRA    = 5'd10;
  localparam exec_op_t EXEC_MUL    = 5'd11;
  localparam exec_op_t EXEC_MULH   = 5'd12;
  localparam exec_op_t EXEC_MULHSU = 5'd13;
  localparam exec_op_t EXEC_MULHU  = 5'd14;
  localparam exec_op_t EXEC_DIV    = 5'd15;
  localparam exec_op_t EXEC_DIVU   = 5'd16;
  localparam exec_op_t EXEC_REM    = 5'd17;
  localparam exec_op_t EXEC_REMU   = 5'd18;
  localparam exec_op_t EXEC_LUI    = 5'd19;
  localparam exec_op_t EXEC_LB     = 5'd20;
  localparam exec_op_t EXEC_LH     = 5'd21;
  localparam exec_op_t EXEC_LW     = 5'd22;
  localparam exec_op_t EXEC_LBU    = 5'd23;
  localparam exec_op_t EXEC_LHU    = 5'd24;
  localparam exec_op_t EXEC_SB     = 5'd25;
  localparam exec_op_t EXEC_SH     = 5'd26;
  localparam exec_op_t EXEC_SW     = 5'd27;
  localparam exec_op_t EXEC_ECALL  = 5'd28;
  localparam exec_op_t EXEC_EBREAK = 5'd29;

  localparam imm_fmt_t IMM_NONE = 3'd0;
  localparam imm_fmt_t IMM_I    = 3'd1;
  localparam imm_fmt_t IMM_S    = 3'd2;
  localparam imm_fmt_t IMM_B    = 3'd3;
  localparam imm_fmt_t IMM_U    = 3'd4;
  localparam imm_fmt_t IMM_J    = 3'd5;

  localparam pc_src_t PC_SEQ    = 2'd0;
  localparam pc_src_t PC_JAL    = 2'd1;
  localparam pc_src_t PC_JALR   = 2'd2;
  localparam pc_src_t PC_BRANCH = 2'd3;

  localparam opa_sel_t OPA_REG  = 2'd0;
  localparam opa_sel_t OPA_PC   = 2'd1;
  localparam opa_sel_t OPA_IMM  = 2'd2;
  localparam opa_sel_t OPA_ZERO = 2'd3;

  localparam opb_sel_t OPB_REG   = 3'd0;
  localparam opb_sel_t OPB_IMM   = 3'd1;
  localparam opb_sel_t OPB_SHAMT = 3'd2;
  localparam opb_sel_t OPB_FOUR  = 3'd3;
  localparam opb_sel_t OPB_ZERO  = 3'd4;

  // branch conditions are the funct3 encodings
  localparam branch_cond_t BR_EQ  = 3'b000;
  localparam branch_cond_t BR_NE  = 3'b001;
  localparam branch_cond_t BR_LT  = 3'b100;
  localparam branch_cond_t BR_GE  = 3'b101;
  localparam branch_cond_t BR_LTU = 3'b110;
  localparam branch_cond_t BR_GEU = 3'b111;

  // major opcodes, instr[6:2]
  localparam logic [4:0] OPC_LOAD   = 5'b00000;
  localparam logic [4:0] OPC_STORE  = 5'b01000;
  localparam logic [4:0] OPC_BRANCH = 5'b11000;
  localparam logic [4:0] OPC_JAL    = 5'b11011;
  localparam logic [4:0] OPC_JALR   = 5'b11001;
  localparam logic [4:0] OPC_OP_IMM = 5'b00100;
  localparam logic [4:0] OPC_OP     = 5'b01100;
  localparam logic [4:0] OPC_LUI    = 5'b01101;
  localparam logic [4:0] OPC_AUIPC  = 5'b00101;
  localparam logic [4:0] OPC_SYSTEM = 5'b11100;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

/* design/rv_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decoder import rv_decode_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  word_t    instr,
  input  word_t    fetch_pc,
  input  word_t    reg_rs1,
  input  word_t    reg_rs2,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output word_t    pc,
  output word_t    mem_addr,
  output word_t    op_a,
  output word_t    op_b,
  output reg_idx_t rd,
  output exec_op_t exec_op,
  output logic     valid_instr
);

  exec_op_t     dec_exec_op;
  pc_src_t      dec_pc_src;
  branch_cond_t dec_branch_cond;
  opa_sel_t     dec_opa_sel;
  opb_sel_t     dec_opb_sel;
  imm_fmt_t     dec_imm_fmt;
  reg_idx_t     dec_rd;
  logic         dec_valid;
  word_t        imm;
  word_t        next_pc;

  // rs1/rs2 leave combinationally for the register file
  instr_classifier u_classifier (
    .instr       (instr),
    .exec_op     (dec_exec_op),
    .pc_src      (dec_pc_src),
    .branch_cond (dec_branch_cond),
    .opa_sel     (dec_opa_sel),
    .opb_sel     (dec_opb_sel),
    .imm_fmt     (dec_imm_fmt),
    .rd          (dec_rd),
    .rs1         (rs1),
    .rs2         (rs2),
    .valid_instr (dec_valid)
  );

  imm_gen u_imm_gen (
    .instr   (instr),
    .imm_fmt (dec_imm_fmt),
    .imm     (imm)
  );

  branch_unit u_branch (
    .fetch_pc    (fetch_pc),
    .reg_rs1     (reg_rs1),
    .reg_rs2     (reg_rs2),
    .imm         (imm),
    .pc_src      (dec_pc_src),
    .branch_cond (dec_branch_cond),
    .next_pc     (next_pc)
  );

  operand_stage u_operands (
    .clk         (clk),
    .reset       (reset),
    .fetch_pc    (fetch_pc),
    .reg_rs1     (reg_rs1),
    .reg_rs2     (reg_rs2),
    .imm         (imm),
    .next_pc     (next_pc),
    .opa_sel     (dec_opa_sel),
    .opb_sel     (dec_opb_sel),
    .exec_op     (dec_exec_op),
    .rd          (dec_rd),
    .valid_instr (dec_valid),
    .pc          (pc),
    .mem_addr    (mem_addr),
    .op_a        (op_a),
    .op_b        (op_b),
    .out_rd      (rd),
    .out_exec_op (exec_op),
    .out_valid   (valid_instr)
  );

endmodule

`default_nettype wire

/* filelist.f */
design/rv_decode_pkg.sv
design/instr_classifier.sv
design/imm_gen.sv
design/branch_unit.sv
design/operand_stage.sv
design/rv_decoder.sv
verif/rv_decoder_sva.sv
verif/tb_rv_decoder.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decoder testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_rv_decoder \
  -o sim_tb_rv_decoder

./obj_dir/sim_tb_rv_decoder > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  exit 1
fi
exit 0

/* verif/rv_decoder_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decoder_sva import rv_decode_pkg::*; (
  input logic     clk,
  input logic     reset,
  input word_t    pc,
  input reg_idx_t rd,
  input exec_op_t exec_op,
  input logic     valid_instr
);

  // an invalid slot carries no operation
  assert property (@(posedge clk) disable iff (reset)
    !valid_instr |-> exec_op == EXEC_NONE)
    else $error("exec_op set while valid_instr is low");

  // stores never write a register
  assert property (@(posedge clk) disable iff (reset)
    (exec_op == EXEC_SB || exec_op == EXEC_SH || exec_op == EXEC_SW) |-> rd == '0)
    else $error("store with nonzero rd");

  assert property (@(posedge clk)
    $fell(reset) |-> (pc == '0 && !valid_instr))
    else $error("outputs not cleared after reset");

endmodule

bind rv_decoder rv_decoder_sva u_sva (
  .clk         (clk),
  .reset       (reset),
  .pc          (pc),
  .rd          (rd),
  .exec_op     (exec_op),
  .valid_instr (valid_instr)
);

`default_nettype wire

/* verif/tb_rv_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_decoder import rv_decode_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int NUM_ROWS     = 33;
  localparam int NUM_RANDOM   = 64;
  localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + NUM_ROWS + NUM_RANDOM + 10);

  logic     clk;
  logic     reset;
  word_t    instr;
  word_t    fetch_pc;
  word_t    reg_rs1;
  word_t    reg_rs2;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    pc;
  word_t    mem_addr;
  word_t    op_a;
  word_t    op_b;
  reg_idx_t rd;
  exec_op_t exec_op;
  logic     valid_instr;

  // stimulus and expected values, one entry per row
  word_t    t_instr [NUM_ROWS];
  word_t    t_fpc   [NUM_ROWS];
  word_t    t_r1    [NUM_ROWS];
  word_t    t_r2    [NUM_ROWS];
  reg_idx_t t_rs1   [NUM_ROWS];
  reg_idx_t t_rs2   [NUM_ROWS];
  word_t    t_pc    [NUM_ROWS];
  word_t    t_mem   [NUM_ROWS];
  word_t    t_opa   [NUM_ROWS];
  word_t    t_opb   [NUM_ROWS];
  reg_idx_t t_rd    [NUM_ROWS];
  exec_op_t t_op    [NUM_ROWS];
  logic     t_valid [NUM_ROWS];

  int       cycle_count;
  int       seed;

  rv_decoder u_dut (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .fetch_pc    (fetch_pc),
    .reg_rs1     (reg_rs1),
    .reg_rs2     (reg_rs2),
    .rs1         (rs1),
    .rs2         (rs2),
    .pc          (pc),
    .mem_addr    (mem_addr),
    .op_a        (op_a),
    .op_b        (op_b),
    .rd          (rd),
    .exec_op     (exec_op),
    .valid_instr (valid_instr)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("[FAIL] %s actual %h expected %h", name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic set_row(input int i, input word_t ins, input word_t fpc, input word_t r1,
                         input word_t r2, input reg_idx_t e_rs1, input reg_idx_t e_rs2,
                         input word_t e_pc, input word_t e_mem, input word_t e_opa,
                         input word_t e_opb, input reg_idx_t e_rd, input exec_op_t e_op,
                         input logic e_valid);
    t_instr[i] = ins;
    t_fpc[i]   = fpc;
    t_r1[i]    = r1;
    t_r2[i]    = r2;
    t_rs1[i]   = e_rs1;
    t_rs2[i]   = e_rs2;
    t_pc[i]    = e_pc;
    t_mem[i]   = e_mem;
    t_opa[i]   = e_opa;
    t_opb[i]   = e_opb;
    t_rd[i]    = e_rd;
    t_op[i]    = e_op;
    t_valid[i] = e_valid;
  endtask

  // drive on the falling edge and check rs1/rs2 before the rising edge
  task automatic apply_and_check(input word_t ins, input word_t fpc, input word_t r1,
                                 input word_t r2, input reg_idx_t e_rs1, input reg_idx_t e_rs2,
                                 input word_t e_pc, input word_t e_mem, input word_t e_opa,
                                 input word_t e_opb, input reg_idx_t e_rd, input exec_op_t e_op,
                                 input logic e_valid);
    @(negedge clk);
    instr    = ins;
    fetch_pc = fpc;
    reg_rs1  = r1;
    reg_rs2  = r2;
    #1;
    check_value("rs1", {27'b0, rs1}, {27'b0, e_rs1});
    check_value("rs2", {27'b0, rs2}, {27'b0, e_rs2});
    @(posedge clk);
    #1;
    check_value("pc", pc, e_pc);
    check_value("mem_addr", mem_addr, e_mem);
    check_value("op_a", op_a, e_opa);
    check_value("op_b", op_b, e_opb);
    check_value("rd", {27'b0, rd}, {27'b0, e_rd});
    check_value("exec_op", {27'b0, exec_op}, {27'b0, e_op});
    check_value("valid_instr", {31'b0, valid_instr}, {31'b0, e_valid});
  endtask

  // RV32IM register-register table
  function automatic exec_op_t r_type_op(input logic [6:0] f7, input logic [2:0] f3);
    if (f7 == F7_MULDIV) begin
      case (f3)
        3'd0:    return EXEC_MUL;
        3'd1:    return EXEC_MULH;
        3'd2:    return EXEC_MULHSU;
        3'd3:    return EXEC_MULHU;
        3'd4:    return EXEC_DIV;
        3'd5:    return EXEC_DIVU;
        3'd6:    return EXEC_REM;
        default: return EXEC_REMU;
      endcase
    end
    case (f3)
      3'd0:    return (f7 == F7_ALT) ? EXEC_SUB : EXEC_ADD;
      3'd1:    return EXEC_SLL;
      3'd2:    return EXEC_SLT;
      3'd3:    return EXEC_SLTU;
      3'd4:    return EXEC_XOR;
      3'd5:    return (f7 == F7_ALT) ? EXEC_SRA : EXEC_SRL;
      3'd6:    return EXEC_OR;
      default: return EXEC_AND;
    endcase
  endfunction

  task automatic run_random_rtype();
    word_t      rnd;
    word_t      kind;
    word_t      ins;
    word_t      fpc;
    word_t      r1;
    word_t      r2;
    logic [6:0] f7;
    logic [2:0] f3;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd  = $random(seed);
      kind = $random(seed);
      fpc  = $random(seed);
      r1   = $random(seed);
      r2   = $random(seed);
      fpc  = {fpc[31:2], 2'b00};
      f3   = rnd[14:12];
      case (kind[1:0])
        2'd2: begin
          // alt form exists only for sub and sra
          f7 = F7_ALT;
          f3 = rnd[12] ? 3'd5 : 3'd0;
        end
        2'd3:    f7 = F7_MULDIV;
        default: f7 = F7_BASE;
      endcase
      ins = {f7, rnd[24:20], rnd[19:15], f3, rnd[11:7], 7'b0110011};
      apply_and_check(ins, fpc, r1, r2, ins[19:15], ins[24:20], fpc + 32'd4,
                      r1 + {{20{ins[31]}}, ins[31:20]}, r1, r2, ins[11:7],
                      r_type_op(f7, f3), 1'b1);
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    // a valid add is held while reset is high
    instr       = 32'h002081B3;
    fetch_pc    = 32'h00001000;
    reg_rs1     = '0;
    reg_rs2     = '0;
    cycle_count = 0;
    seed        = 32'hb149;

    // r-type and m-extension
    set_row(0, 32'h002081B3, 32'h00001000, 32'h00000011, 32'h00000022,
            1, 2, 32'h00001004, 32'h00000013, 32'h00000011, 32'h00000022, 3, EXEC_ADD, 1);
    set_row(1, 32'h407302B3, 32'h00002000, 32'h00000100, 32'h00000050,
            6, 7, 32'h00002004, 32'h00000507, 32'h00000100, 32'h00000050, 5, EXEC_SUB, 1);
    set_row(2, 32'h02C5B533, 32'h00003000, 32'hFFFFFFF0, 32'h00000003,
            11, 12, 32'h00003004, 32'h0000001C, 32'hFFFFFFF0, 32'h00000003, 10, EXEC_MULHU, 1);
    set_row(3, 32'h403150B3, 32'h00003004, 32'h80000000, 32'h00000004,
            2, 3, 32'h00003008, 32'h80000403, 32'h80000000, 32'h00000004, 1, EXEC_SRA, 1);
    // immediate forms
    set_row(4, 32'hFFF28213, 32'h00004000, 32'h00000010, 32'h00000099,
            5, 31, 32'h00004004, 32'h0000000F, 32'h00000010, 32'hFFFFFFFF, 4, EXEC_ADD, 1);
    set_row(5, 32'h7FF3C313, 32'h00004004, 32'h00001234, 32'h00000000,
            7, 31, 32'h00004008, 32'h00001A33, 32'h00001234, 32'h000007FF, 6, EXEC_XOR, 1);
    set_row(6, 32'h8004A413, 32'h00004008, 32'h00005000, 32'h00000000,
            9, 0, 32'h0000400C, 32'h00004800, 32'h00005000, 32'hFFFFF800, 8, EXEC_SLT, 1);
    set_row(7, 32'h01F11093, 32'h0000400C, 32'h00000001, 32'h00000000,
            2, 31, 32'h00004010, 32'h00000020, 32'h00000001, 32'h0000001F, 1, EXEC_SLL, 1);
    set_row(8, 32'h40725193, 32'h00004010, 32'hF0000000, 32'h00000000,
            4, 7, 32'h00004014, 32'hF0000407, 32'hF0000000, 32'h00000007, 3, EXEC_SRA, 1);
    set_row(9, 32'hABCDE2B7, 32'h00004014, 32'h00000000, 32'h00000033,
            27, 28, 32'h00004018, 32'hABCDE000, 32'hABCDE000, 32'h00000000, 5, EXEC_LUI, 1);
    set_row(10, 32'h12345317, 32'h00000100, 32'h00000000, 32'h00000000,
            8, 3, 32'h00000104, 32'h12345000, 32'h00000100, 32'h12345000, 6, EXEC_ADD, 1);
    // branches with offset +16, each taken then not taken
    set_row(11, 32'h00208863, 32'h00008000, 32'h00000005, 32'h00000005,
            1, 2, 32'h00008010, 32'h00000015, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    set_row(12, 32'h00208863, 32'h00008000, 32'h00000005, 32'h00000006,
            1, 2, 32'h00008004, 32'h00000015, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    set_row(13, 32'h00209863, 32'h00008000, 32'h00000000, 32'h00000001,
            1, 2, 32'h00008010, 32'h00000010, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    set_row(14, 32'h00209863, 32'h00008000, 32'h00000007, 32'h00000007,
            1, 2, 32'h00008004, 32'h00000017, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    set_row(15, 32'h0020C863, 32'h00008000, 32'hFFFFFFFF, 32'h00000000,
            1, 2, 32'h00008010, 32'h0000000F, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    set_row(16, 32'h0020C863, 32'h00008000, 32'h7FFFFFFF, 32'h80000000,
            1, 2, 32'h00008004, 32'h8000000F, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    set_row(17, 32'h0020D863, 32'h00008000, 32'h7FFFFFFF, 32'h80000000,
            1, 2, 32'h00008010, 32'h8000000F, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    set_row(18, 32'h0020D863, 32'h00008000, 32'h80000000, 32'h00000000,
            1, 2, 32'h00008004, 32'h80000010, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    set_row(19, 32'h0020E863, 32'h00008000, 32'h00000000, 32'hFFFFFFFF,
            1, 2, 32'h00008010, 32'h00000010, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    set_row(20, 32'h0020E863, 32'h00008000, 32'hFFFFFFFF, 32'h00000000,
            1, 2, 32'h00008004, 32'h0000000F, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    set_row(21, 32'h0020F863, 32'h00008000, 32'h80000000, 32'h7FFFFFFF,
            1, 2, 32'h00008010, 32'h80000010, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    set_row(22, 32'h0020F863, 32'h00008000, 32'h00000001, 32'h00000002,
            1, 2, 32'h00008004, 32'h00000011, 32'h0, 32'h0, 0, EXEC_NONE, 1);
    // jal +0x800, jalr 3(x5)
    set_row(23, 32'h001000EF, 32'h00009000, 32'h00000000, 32'h00000000,
            0, 1, 32'h00009800, 32'h00000800, 32'h00009000, 32'h00000004, 1, EXEC_ADD, 1);
    set_row(24, 32'h003280E7, 32'h0000A000, 32'h00002000, 32'h00000000,
            5, 3, 32'h00002002, 32'h00002003, 32'h0000A000, 32'h00000004, 1, EXEC_ADD, 1);
    // loads and stores
    set_row(25, 32'hFFC12383, 32'h0000B000, 32'h00000100, 32'h00000000,
            2, 28, 32'h0000B004, 32'h000000FC, 32'h00000100, 32'hFFFFFFFC, 7, EXEC_LW, 1);
    set_row(26, 32'h0011C403, 32'h0000B004, 32'h00000200, 32'h00000000,
            3, 1, 32'h0000B008, 32'h00000201, 32'h00000200, 32'h00000001, 8, EXEC_LBU, 1);
    set_row(27, 32'h0042A423, 32'h0000B008, 32'h00001000, 32'hDEADBEEF,
            5, 4, 32'h0000B00C, 32'h00001008, 32'h00001000, 32'hDEADBEEF, 0, EXEC_SW, 1);
    set_row(28, 32'hFE638FA3, 32'h0000B00C, 32'h00000010, 32'h000000AB,
            7, 6, 32'h0000B010, 32'h0000000F, 32'h00000010, 32'h000000AB, 0, EXEC_SB, 1);
    // ecall, ebreak, then a compressed and a csr encoding
    set_row(29, 32'h00000073, 32'h0000C000, 32'h00000000, 32'h00000000,
            0, 0, 32'h0000C004, 32'h00000000, 32'h0, 32'h0, 0, EXEC_ECALL, 1);
    set_row(30, 32'h00100073, 32'h0000C004, 32'h00000000, 32'h00000000,
            0, 1, 32'h0000C008, 32'h00000001, 32'h0, 32'h0, 0, EXEC_EBREAK, 1);
    set_row(31, 32'h00004501, 32'h0000C008, 32'h00000055, 32'h00000066,
            0, 0, 32'h0000C00C, 32'h00000055, 32'h00000055, 32'h00000066, 0, EXEC_NONE, 0);
    set_row(32, 32'h300110F3, 32'h0000C00C, 32'h00000077, 32'h00000088,
            2, 0, 32'h0000C010, 32'h00000077, 32'h00000077, 32'h00000088, 0, EXEC_NONE, 0);

    @(posedge clk);
    #1;
    check_value("pc", pc, 32'h0);
    check_value("valid_instr", {31'b0, valid_instr}, 32'h0);
    check_value("exec_op", {27'b0, exec_op}, {27'b0, EXEC_NONE});
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #1;
    // still the reset values until the next edge
    check_value("pc", pc, 32'h0);
    check_value("valid_instr", {31'b0, valid_instr}, 32'h0);
    check_value("exec_op", {27'b0, exec_op}, {27'b0, EXEC_NONE});

    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_and_check(t_instr[i], t_fpc[i], t_r1[i], t_r2[i], t_rs1[i], t_rs2[i], t_pc[i],
                      t_mem[i], t_opa[i], t_opb[i], t_rd[i], t_op[i], t_valid[i]);
    end
    run_random_rtype();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
